// File: ppu_cfg.svh
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// the posit word is 16 bits wide with one exponent bit.
`define PPU_N 16
`define PPU_ES 1

`define PPU_TE_BITS 7         // signed total exponent, regime times 2^es plus exponent.
`define PPU_MANT_SIZE 14      // hidden bit and the fraction below it.
`define PPU_FRAC_FULL_SIZE 28 // fraction after the leading one, handed to the encoder.

// the adder keeps a carry bit on top and three low bits for guard, round and sticky.
`define PPU_ADD_GUARD 3
`define PPU_ADD_SIZE (`PPU_MANT_SIZE + `PPU_ADD_GUARD + 1)

`define PPU_MUL_SIZE (2 * `PPU_MANT_SIZE)
`define PPU_RAW_SIZE (`PPU_FRAC_FULL_SIZE + 1) // normaliser input with one bit of headroom.

// total exponents outside this range saturate to maxpos or minpos.
`define PPU_TE_MAX 27
`define PPU_TE_MIN (-28)

`endif

// File: ppu_pkg.sv
`default_nettype none

`include "ppu_cfg.svh"

package ppu_pkg;

  typedef logic [`PPU_N-1:0] posit_t;

  // a number is 1.frac times 2^te once decoded.
  typedef logic signed [`PPU_TE_BITS-1:0] exponent_t;

  typedef logic [`PPU_MANT_SIZE-1:0] mant_t;          // hidden bit sits at the msb.
  typedef logic [`PPU_FRAC_FULL_SIZE-1:0] frac_full_t;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2,
    DIV = 2'd3
  } operation_e;

endpackage : ppu_pkg

`default_nettype wire

// File: posit_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "ppu_cfg.svh"

module posit_decode (
  input  ppu_pkg::posit_t    posit_i,
  output logic               sign_o,
  output ppu_pkg::exponent_t te_o,
  output ppu_pkg::mant_t     mant_o,
  output logic               zero_o,
  output logic               nar_o
);

  localparam int BODY_W = `PPU_N - 1;

  ppu_pkg::posit_t    mag;
  logic [BODY_W-1:0]  body;
  logic [BODY_W-1:0]  rest;
  logic [4:0]         run;
  logic [4:0]         skip;
  logic               run_done;
  ppu_pkg::exponent_t k;

  assign sign_o = posit_i[`PPU_N-1];
  assign zero_o = (posit_i == '0);
  assign nar_o  = (posit_i == {1'b1, {(`PPU_N-1){1'b0}}});

  assign mag  = sign_o ? -posit_i : posit_i; // negative posits decode from their two's complement.
  assign body = mag[BODY_W-1:0];

  // the regime is a run of equal bits starting just below the sign.
  always_comb begin
    run      = '0;
    run_done = 1'b0;
    for (int i = BODY_W - 1; i >= 0; i--) begin
      if (!run_done && body[i] == body[BODY_W-1]) begin
        run = run + 5'd1;
      end else begin
        run_done = 1'b1;
      end
    end
  end

  // a run of ones gives k = run - 1, a run of zeros gives k = -run.
  assign k = body[BODY_W-1] ? ppu_pkg::exponent_t'(run - 5'd1) : -ppu_pkg::exponent_t'(run);

  assign skip = run + 5'd1;    // drop the run and its terminating bit.
  assign rest = body << skip;

  assign te_o = (k <<< `PPU_ES) + ppu_pkg::exponent_t'(rest[BODY_W-1 -: `PPU_ES]);

  // Whatever fraction bits remain are left aligned under the hidden bit.
  assign mant_o = {1'b1, rest[BODY_W-1-`PPU_ES -: `PPU_MANT_SIZE-1]};

endmodule : posit_decode

`default_nettype wire

// File: core_add_sub.sv
`timescale 1ns/100ps
`default_nettype none

`include "ppu_cfg.svh"

module core_add_sub (
  input  ppu_pkg::exponent_t       te1_i,
  input  ppu_pkg::exponent_t       te2_i,
  input  ppu_pkg::mant_t           mant1_i,
  input  ppu_pkg::mant_t           mant2_i,
  input  logic                     sign1_i,
  input  logic                     sign2_i,
  input  logic                     sub_i,
  output logic [`PPU_ADD_SIZE-1:0] mant_o,
  output ppu_pkg::exponent_t       te_o,
  output logic                     sign_o,
  output logic                     frac_truncated_o
);

  localparam int ALIGN_W = `PPU_MANT_SIZE + `PPU_ADD_GUARD;

  logic                    sign2_eff;
  logic                    swap;
  logic                    eff_sub;
  ppu_pkg::exponent_t      te_small;
  ppu_pkg::mant_t          mant_big;
  ppu_pkg::mant_t          mant_small;
  logic [`PPU_TE_BITS-1:0] diff;
  logic [`PPU_TE_BITS-1:0] shamt;
  logic [2*ALIGN_W-1:0]    shift_win;
  logic [ALIGN_W-1:0]      small_al;
  logic                    sticky;

  assign sign2_eff = sign2_i ^ sub_i;
  assign eff_sub   = sign1_i ^ sign2_eff;

  // The larger magnitude goes first so that a subtraction never goes negative.
  assign swap = (te2_i > te1_i) || (te2_i == te1_i && mant2_i > mant1_i);

  assign te_o       = swap ? te2_i : te1_i;
  assign te_small   = swap ? te1_i : te2_i;
  assign mant_big   = swap ? mant2_i : mant1_i;
  assign mant_small = swap ? mant1_i : mant2_i;
  assign sign_o     = swap ? sign2_eff : sign1_i;

  assign diff  = te_o - te_small;
  assign shamt = (diff > `PPU_TE_BITS'(ALIGN_W)) ? `PPU_TE_BITS'(ALIGN_W) : diff;

  // the lower half of the window catches every bit shifted past the guard bits.
  assign shift_win = {mant_small, {`PPU_ADD_GUARD{1'b0}}, {ALIGN_W{1'b0}}} >> shamt;
  assign sticky    = |shift_win[ALIGN_W-1:0];
  assign small_al  = {shift_win[2*ALIGN_W-1:ALIGN_W+1], shift_win[ALIGN_W] | sticky};

  assign mant_o = eff_sub ? {1'b0, mant_big, {`PPU_ADD_GUARD{1'b0}}} - {1'b0, small_al}
                          : {1'b0, mant_big, {`PPU_ADD_GUARD{1'b0}}} + {1'b0, small_al};

  assign frac_truncated_o = sticky;

endmodule : core_add_sub

`default_nettype wire

// File: core_op.sv
`timescale 1ns/100ps
`default_nettype none

`include "ppu_cfg.svh"

module core_op (
  input  ppu_pkg::operation_e op_i,
  input  logic                sign1_i,
  input  logic                sign2_i,
  input  ppu_pkg::exponent_t  te1_i,
  input  ppu_pkg::exponent_t  te2_i,
  input  ppu_pkg::mant_t      mant1_i,
  input  ppu_pkg::mant_t      mant2_i,
  input  logic                zero1_i,
  input  logic                zero2_i,
  input  logic                nar1_i,
  input  logic                nar2_i,
  output logic                sign_o,
  output ppu_pkg::exponent_t  te_o,
  output ppu_pkg::frac_full_t frac_o,
  output logic                frac_truncated_o,
  output logic                zero_o,
  output logic                nar_o
);

  localparam int RAW_W = `PPU_RAW_SIZE;
  localparam int UNIT  = RAW_W - 2; // raw bit that weighs 2^te_base.

  logic [`PPU_ADD_SIZE-1:0]      add_mant;
  ppu_pkg::exponent_t            add_te;
  logic                          add_sign;
  logic                          add_sticky;
  logic                          is_sub;
  logic [`PPU_MUL_SIZE-1:0]      mul_mant;
  logic [`PPU_FRAC_FULL_SIZE-1:0] div_quot;
  logic [`PPU_MANT_SIZE:0]       div_rem;
  logic                          div_sticky;
  logic [RAW_W-1:0]              raw;
  logic [RAW_W-1:0]              raw_sh;
  ppu_pkg::exponent_t            te_base;
  logic [4:0]                    lead;

  assign is_sub = (op_i == ppu_pkg::SUB);

  core_add_sub u_add_sub (
    .te1_i            (te1_i),
    .te2_i            (te2_i),
    .mant1_i          (mant1_i),
    .mant2_i          (mant2_i),
    .sign1_i          (sign1_i),
    .sign2_i          (sign2_i),
    .sub_i            (is_sub),
    .mant_o           (add_mant),
    .te_o             (add_te),
    .sign_o           (add_sign),
    .frac_truncated_o (add_sticky)
  );

  assign mul_mant = mant1_i * mant2_i; // exact, so multiply never sets the sticky bit.

  // restoring division, one quotient bit per step with the integer bit first.
  always_comb begin
    div_rem  = {1'b0, mant1_i};
    div_quot = '0;
    for (int i = `PPU_FRAC_FULL_SIZE - 1; i >= 0; i--) begin
      if (div_rem >= {1'b0, mant2_i}) begin
        div_quot[i] = 1'b1;
        div_rem     = div_rem - {1'b0, mant2_i};
      end
      div_rem = div_rem << 1;
    end
  end

  assign div_sticky = |div_rem;

  // Every result is placed in raw with its unit bit at UNIT.
  always_comb begin
    case (op_i)
      ppu_pkg::MUL: begin
        sign_o           = sign1_i ^ sign2_i;
        te_base          = te1_i + te2_i;
        raw              = {mul_mant, 1'b0};
        frac_truncated_o = 1'b0;
      end
      ppu_pkg::DIV: begin
        sign_o           = sign1_i ^ sign2_i;
        te_base          = te1_i - te2_i;
        raw              = {1'b0, div_quot};
        frac_truncated_o = div_sticky;
      end
      default: begin
        if (zero1_i) begin // 0 + b and 0 - b come out as b or -b.
          sign_o           = sign2_i ^ is_sub;
          te_base          = te2_i;
          raw              = {1'b0, mant2_i, {(RAW_W-1-`PPU_MANT_SIZE){1'b0}}};
          frac_truncated_o = 1'b0;
        end else if (zero2_i) begin
          sign_o           = sign1_i;
          te_base          = te1_i;
          raw              = {1'b0, mant1_i, {(RAW_W-1-`PPU_MANT_SIZE){1'b0}}};
          frac_truncated_o = 1'b0;
        end else begin
          sign_o           = add_sign;
          te_base          = add_te;
          raw              = {add_mant, {(RAW_W-`PPU_ADD_SIZE){1'b0}}};
          frac_truncated_o = add_sticky;
        end
      end
    endcase
  end

  always_comb begin
    lead = '0;
    for (int i = 0; i < RAW_W; i++) begin
      if (raw[i]) begin
        lead = 5'(i);
      end
    end
  end

  assign raw_sh = raw << (5'(RAW_W - 1) - lead); // the leading one falls off the top.
  assign frac_o = raw_sh[RAW_W-2:0];
  assign te_o   = te_base + ppu_pkg::exponent_t'(lead) - ppu_pkg::exponent_t'(UNIT);

  assign nar_o = nar1_i | nar2_i | (op_i == ppu_pkg::DIV && zero2_i);

  always_comb begin
    case (op_i)
      ppu_pkg::MUL: zero_o = zero1_i | zero2_i;
      ppu_pkg::DIV: zero_o = zero1_i;
      default:      zero_o = (zero1_i & zero2_i) | (!zero1_i & !zero2_i & (add_mant == '0));
    endcase
  end

endmodule : core_op

`default_nettype wire

// File: posit_encode.sv
`timescale 1ns/100ps
`default_nettype none

`include "ppu_cfg.svh"

module posit_encode (
  input  logic                sign_i,
  input  ppu_pkg::exponent_t  te_i,
  input  ppu_pkg::frac_full_t frac_i,
  input  logic                frac_truncated_i,
  input  logic                zero_i,
  input  logic                nar_i,
  output ppu_pkg::posit_t     posit_o
);

  localparam int BODY_W = `PPU_N - 1;
  localparam int FRAC_W = `PPU_FRAC_FULL_SIZE;
  localparam int SEED_W = 2 + `PPU_ES + FRAC_W;
  localparam int EXT_W  = SEED_W + BODY_W - 2;   // room for the longest regime run.

  ppu_pkg::exponent_t      k;
  logic                    k_neg;
  logic [3:0]              shamt;
  logic [SEED_W-1:0]       seed;
  logic [EXT_W-1:0]        ext_seed;
  logic signed [EXT_W-1:0] ext_ones;
  logic [EXT_W-1:0]        ext;
  logic [BODY_W-1:0]       body;
  logic                    guard;
  logic                    sticky;
  logic                    cut_exp;
  logic                    frac_above;
  logic                    frac_tie;
  logic                    round_up;
  ppu_pkg::posit_t         mag;
  ppu_pkg::posit_t         mag_sat;

  assign k     = te_i >>> `PPU_ES;
  assign k_neg = k[`PPU_TE_BITS-1];
  assign shamt = k_neg ? 4'(~k) : 4'(k);

  // The seed starts the regime with 10 or 01 and is then stretched by the shift.
  assign seed     = {~k_neg, k_neg, te_i[`PPU_ES-1:0], frac_i};
  assign ext_seed = {seed, {(EXT_W-SEED_W){1'b0}}};
  assign ext_ones = $signed(ext_seed) >>> shamt; // ones fill in for a positive k.
  assign ext      = k_neg ? (ext_seed >> shamt) : ext_ones;

  assign body   = ext[EXT_W-1 -: BODY_W];
  assign guard  = ext[EXT_W-1-BODY_W];
  assign sticky = (|ext[EXT_W-2-BODY_W:0]) | frac_truncated_i;

  // at the two outermost regimes the exponent bit itself is the guard bit.
  assign cut_exp = (k == ppu_pkg::exponent_t'(BODY_W - 2)) ||
                   (k == -ppu_pkg::exponent_t'(BODY_W - 1));

  // Neighbours there are a factor of four apart, so the midpoint sits at 1.25 times 2^te.
  assign frac_above = frac_i[FRAC_W-1] |
                      (frac_i[FRAC_W-2] & ((|frac_i[FRAC_W-3:0]) | frac_truncated_i));
  assign frac_tie   = ~frac_i[FRAC_W-1] & frac_i[FRAC_W-2] &
                      ~(|frac_i[FRAC_W-3:0]) & ~frac_truncated_i;

  assign round_up = cut_exp ? guard & (frac_above | (frac_tie & body[0]))
                            : guard & (sticky | body[0]);

  assign mag = {1'b0, body} + `PPU_N'(round_up);

  always_comb begin
    if (te_i > ppu_pkg::exponent_t'(`PPU_TE_MAX)) begin
      mag_sat = {1'b0, {(`PPU_N-1){1'b1}}};            // maxpos.
    end else if (te_i < ppu_pkg::exponent_t'(`PPU_TE_MIN)) begin
      mag_sat = `PPU_N'(1);                            // minpos, never zero.
    end else begin
      mag_sat = mag;
    end
  end

  always_comb begin
    if (nar_i) begin
      posit_o = {1'b1, {(`PPU_N-1){1'b0}}};
    end else if (zero_i) begin
      posit_o = '0;
    end else begin
      posit_o = sign_i ? -mag_sat : mag_sat;
    end
  end

endmodule : posit_encode

`default_nettype wire

// File: ppu.sv
`timescale 1ns/100ps
`default_nettype none

module ppu (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                valid_i,
  output logic                ready_o,
  input  ppu_pkg::operation_e op_i,
  input  ppu_pkg::posit_t     a_i,
  input  ppu_pkg::posit_t     b_i,
  output logic                valid_o,
  input  logic                ready_i,
  output ppu_pkg::posit_t     result_o
);

  logic                a_sign, b_sign, a_zero, b_zero, a_nar, b_nar;
  ppu_pkg::exponent_t  a_te, b_te;
  ppu_pkg::mant_t      a_mant, b_mant;

  logic                s1_valid;
  ppu_pkg::operation_e s1_op;
  logic                s1_sign1, s1_sign2, s1_zero1, s1_zero2, s1_nar1, s1_nar2;
  ppu_pkg::exponent_t  s1_te1, s1_te2;
  ppu_pkg::mant_t      s1_mant1, s1_mant2;

  logic                op_sign, op_trunc, op_zero, op_nar;
  ppu_pkg::exponent_t  op_te;
  ppu_pkg::frac_full_t op_frac;
  ppu_pkg::posit_t     enc_posit;
  logic                s2_ready;

  posit_decode u_decode_a (
    .posit_i (a_i),
    .sign_o  (a_sign),
    .te_o    (a_te),
    .mant_o  (a_mant),
    .zero_o  (a_zero),
    .nar_o   (a_nar)
  );

  posit_decode u_decode_b (
    .posit_i (b_i),
    .sign_o  (b_sign),
    .te_o    (b_te),
    .mant_o  (b_mant),
    .zero_o  (b_zero),
    .nar_o   (b_nar)
  );

  assign s2_ready = !valid_o || ready_i;
  assign ready_o  = !s1_valid || s2_ready; // stage 1 takes data when empty or draining.

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid <= 1'b0;
      valid_o  <= 1'b0;
    end else begin
      if (ready_o) begin
        s1_valid <= valid_i;
      end
      if (s2_ready) begin
        valid_o <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      s1_op    <= op_i;
      s1_sign1 <= a_sign;
      s1_sign2 <= b_sign;
      s1_te1   <= a_te;
      s1_te2   <= b_te;
      s1_mant1 <= a_mant;
      s1_mant2 <= b_mant;
      s1_zero1 <= a_zero;
      s1_zero2 <= b_zero;
      s1_nar1  <= a_nar;
      s1_nar2  <= b_nar;
    end
    if (s1_valid && s2_ready) begin
      result_o <= enc_posit;
    end
  end

  core_op u_core_op (
    .op_i             (s1_op),
    .sign1_i          (s1_sign1),
    .sign2_i          (s1_sign2),
    .te1_i            (s1_te1),
    .te2_i            (s1_te2),
    .mant1_i          (s1_mant1),
    .mant2_i          (s1_mant2),
    .zero1_i          (s1_zero1),
    .zero2_i          (s1_zero2),
    .nar1_i           (s1_nar1),
    .nar2_i           (s1_nar2),
    .sign_o           (op_sign),
    .te_o             (op_te),
    .frac_o           (op_frac),
    .frac_truncated_o (op_trunc),
    .zero_o           (op_zero),
    .nar_o            (op_nar)
  );

  posit_encode u_encode (
    .sign_i           (op_sign),
    .te_i             (op_te),
    .frac_i           (op_frac),
    .frac_truncated_i (op_trunc),
    .zero_i           (op_zero),
    .nar_i            (op_nar),
    .posit_o          (enc_posit)
  );

endmodule : ppu

`default_nettype wire

// File: tb_ppu_model.svh
`ifndef TB_PPU_MODEL_SVH
`define TB_PPU_MODEL_SVH

`include "ppu_cfg.svh"

localparam ppu_pkg::posit_t NAR_WORD    = {1'b1, {(`PPU_N-1){1'b0}}};
localparam ppu_pkg::posit_t MAXPOS_WORD = {1'b0, {(`PPU_N-1){1'b1}}};
localparam ppu_pkg::posit_t MINPOS_WORD = `PPU_N'(1);

function automatic real pow2(input int x);
  real r;
  r = 1.0;
  if (x >= 0) begin
    repeat (x) r = r * 2.0;
  end else begin
    repeat (-x) r = r / 2.0;
  end
  return r;
endfunction

// value of a posit read straight from its bit fields; zero and NaR are handled by the callers.
function automatic real posit_to_real(input ppu_pkg::posit_t p);
  ppu_pkg::posit_t mag;
  int              i;
  int              k;
  int              e;
  real             frac;
  real             step;
  logic            run_bit;
  if (p == '0) return 0.0;
  mag     = p[`PPU_N-1] ? -p : p;
  i       = `PPU_N - 2;
  run_bit = mag[i];
  k       = 0;
  while (i >= 0 && mag[i] == run_bit) begin
    k++;
    i--;
  end
  k = run_bit ? k - 1 : -k;
  i--; // the bit that ends the regime run.
  e = 0;
  for (int j = 0; j < `PPU_ES; j++) begin
    e = 2 * e + ((i >= 0) ? int'(mag[i]) : 0);
    i--;
  end
  frac = 1.0;
  step = 0.5;
  while (i >= 0) begin
    if (mag[i]) frac = frac + step;
    step = step / 2.0;
    i--;
  end
  frac = frac * pow2(k * (1 << `PPU_ES) + e);
  return p[`PPU_N-1] ? -frac : frac;
endfunction

// positive patterns grow with their value, so bisection brackets the magnitude.
function automatic ppu_pkg::posit_t nearest_posit(input real v);
  real             mag;
  real             d_lo;
  real             d_hi;
  int              lo;
  int              hi;
  int              mid;
  ppu_pkg::posit_t p;
  if (v == 0.0) return '0;
  mag = (v < 0.0) ? -v : v;
  if (mag >= posit_to_real(MAXPOS_WORD)) begin
    p = MAXPOS_WORD;
  end else if (mag <= posit_to_real(MINPOS_WORD)) begin
    p = MINPOS_WORD;
  end else begin
    lo = 1;
    hi = int'(MAXPOS_WORD);
    while (hi - lo > 1) begin
      mid = (lo + hi) / 2;
      if (posit_to_real(ppu_pkg::posit_t'(mid)) <= mag) lo = mid;
      else hi = mid;
    end
    d_lo = mag - posit_to_real(ppu_pkg::posit_t'(lo));
    d_hi = posit_to_real(ppu_pkg::posit_t'(hi)) - mag;
    if (d_lo < d_hi) p = ppu_pkg::posit_t'(lo);
    else if (d_hi < d_lo) p = ppu_pkg::posit_t'(hi);
    else p = ppu_pkg::posit_t'((lo % 2 == 0) ? lo : hi); // a tie goes to the even pattern.
  end
  return (v < 0.0) ? -p : p;
endfunction

function automatic ppu_pkg::posit_t expected_result(input ppu_pkg::operation_e op,
                                                    input ppu_pkg::posit_t a,
                                                    input ppu_pkg::posit_t b);
  real ra;
  real rb;
  real r;
  if (a == NAR_WORD || b == NAR_WORD) return NAR_WORD;
  if (op == ppu_pkg::DIV && b == '0) return NAR_WORD;
  ra = posit_to_real(a);
  rb = posit_to_real(b);
  case (op)
    ppu_pkg::ADD: r = ra + rb;
    ppu_pkg::SUB: r = ra - rb;
    ppu_pkg::MUL: r = ra * rb;
    default:      r = ra / rb;
  endcase
  return nearest_posit(r);
endfunction

task automatic check_posit(input string what, input ppu_pkg::posit_t got,
                           input ppu_pkg::posit_t expected);
  check_count++;
  if (got !== expected) begin
    error_count++;
    $display("FAILED at %0t: %s result %h, expected %h", $time, what, got, expected);
  end
endtask

`endif

// File: tb_ppu.sv
`timescale 1ns/100ps
`default_nettype none

`include "ppu_cfg.svh"

module tb_ppu;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 10;
  localparam int RAND_COUNT    = 2000;
  localparam int SPECIAL_COUNT = 300;
  localparam int TOTAL_ITEMS   = 4 * RAND_COUNT + SPECIAL_COUNT;

  logic                clk_i;
  logic                arst_n_i;
  logic                valid_i;
  logic                ready_o;
  ppu_pkg::operation_e op_i;
  ppu_pkg::posit_t     a_i;
  ppu_pkg::posit_t     b_i;
  logic                valid_o;
  logic                ready_i;
  ppu_pkg::posit_t     result_o;

  int              error_count = 0;
  int              check_count = 0;
  int              test_count  = 0;
  ppu_pkg::posit_t exp_q[$]; // expected results of accepted items in arrival order.

  `include "tb_ppu_model.svh"

  ppu UUT (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .op_i     (op_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .result_o (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // about twenty cycles per item is far beyond the slowest back-pressure pattern.
  initial begin : watchdog
    #(TOTAL_ITEMS * 20 * CLK_PERIOD);
    $display("timeout: the DUT stopped delivering results before all tests finished");
    $display("** FAIL **");
    $finish;
  end

  task automatic check_flag(input string what, input logic got, input logic expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  task automatic make_item(input int kind, output ppu_pkg::operation_e op,
                           output ppu_pkg::posit_t a, output ppu_pkg::posit_t b);
    int pick;
    a    = ppu_pkg::posit_t'($urandom);
    b    = ppu_pkg::posit_t'($urandom);
    op   = ppu_pkg::operation_e'($urandom_range(3));
    pick = $urandom_range(7);
    case (kind)
      0: begin
        op = $urandom_range(1) ? ppu_pkg::SUB : ppu_pkg::ADD;
        if (pick == 0) b = (op == ppu_pkg::SUB) ? a : -a; // exact cancellation.
      end
      1: op = ppu_pkg::MUL;
      2: op = ppu_pkg::DIV;
      3: begin
        case (pick % 6)
          0: a = NAR_WORD;
          1: b = NAR_WORD;
          2: begin
            op = ppu_pkg::DIV;
            b  = '0;
          end
          3: a = '0;
          4: b = '0;
          default: begin
            a  = '0;
            b  = '0;
            op = ppu_pkg::SUB;
          end
        endcase
      end
      default: ;
    endcase
  endtask

  // handshake values are stable from just after the falling edge up to the rising edge.
  task automatic run_test(input string name, input int kind, input int count,
                          input int gap_pct, input int stall_pct);
    int                  sent;
    int                  done;
    int                  occupancy;
    int                  errors_before;
    logic                taken;
    ppu_pkg::operation_e op;
    ppu_pkg::posit_t     a;
    ppu_pkg::posit_t     b;
    sent          = 0;
    done          = 0;
    taken         = 1'b0;
    errors_before = error_count;
    while (done < count) begin
      @(negedge clk_i);
      if (taken) valid_i = 1'b0;
      if (!valid_i && sent < count && $urandom_range(99) >= gap_pct) begin
        make_item(kind, op, a, b);
        op_i    = op;
        a_i     = a;
        b_i     = b;
        valid_i = 1'b1;
        sent++;
      end
      ready_i = ($urandom_range(99) >= stall_pct);
      #1;
      occupancy = exp_q.size();
      check_flag("ready_o", ready_o, (occupancy < 2) || ready_i);
      taken = valid_i && ready_o;
      if (taken) exp_q.push_back(expected_result(op_i, a_i, b_i));
      if (valid_o && ready_i) begin
        if (occupancy == 0) begin
          error_count++;
          $display("error: the DUT delivered a result at %0t with no input pending", $time);
        end else begin
          check_posit(name, result_o, exp_q.pop_front());
        end
        done++;
      end
    end
    test_count++;
    $display("test %s finished: %0d items, %0d errors", name, count,
             error_count - errors_before);
  endtask

  initial begin : main
    void'($urandom(32'h6f41));
    arst_n_i = 1'b0;
    valid_i  = 1'b0;
    ready_i  = 1'b0; // ready_o then depends only on whether the stages are empty.
    op_i     = ppu_pkg::ADD;
    a_i      = '0;
    b_i      = '0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    #1;
    check_flag("valid_o after reset", valid_o, 1'b0);
    check_flag("ready_o after reset", ready_o, 1'b1);
    test_count++;
    $display("test reset finished: %0d errors", error_count);

    run_test("add_sub", 0, RAND_COUNT, 0, 0);
    run_test("multiply", 1, RAND_COUNT, 0, 0);
    run_test("divide", 2, RAND_COUNT, 0, 0);
    run_test("specials", 3, SPECIAL_COUNT, 0, 0);
    run_test("back_pressure", 4, RAND_COUNT, 40, 50);

    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_ppu

`default_nettype wire

// File: files.f
+incdir+.
ppu_pkg.sv
posit_decode.sv
core_add_sub.sv
core_op.sv
posit_encode.sv
ppu.sv
tb_ppu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_ppu
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
